/* project.f */
+incdir+rtl
rtl/pio_wmem_pkg.sv
rtl/ram_1r1w.sv
rtl/pio_rw_wmem.sv
rtl/pio_addr_decode.sv
rtl/pio_rdata_merge.sv
rtl/pio_wmem_bank.sv
testbench/tb_pio_wmem_bank.sv

/* run_sim.sh */
#!/bin/sh
# Build the bank testbench with Verilator, run it and scan the log for failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_pio_wmem_bank -o sim_pio_wmem_bank || exit 1

./obj_dir/sim_pio_wmem_bank > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

/* testbench/tb_pio_wmem_bank.sv */
// Testbench for the wide lookup table bank. Drives PIO accesses and app traffic
// on all tables and checks every response against a model of the tables.
// Run through project.f, the top module is tb_pio_wmem_bank.
`timescale 1ns/1ps
`default_nettype none

`include "pio_wmem_macros.svh"

module tb_pio_wmem_bank;

	localparam int NT = `WMEM_NUM;
	localparam int N_INIT = 64;
	localparam int N_DIRECTED = 200;
	localparam int N_RANDOM = 300;
	localparam int N_OPS = N_INIT + N_DIRECTED + N_RANDOM;
	localparam int LIMIT = 40 * N_OPS + 1000;

	logic clk = 1'b0;
	logic arst_n;
	logic clk_div;
	pio_wmem_pkg::pio_req_t                pio_req;
	pio_wmem_pkg::pio_rsp_t                pio_rsp;
	pio_wmem_pkg::app_rd_t  [NT-1:0]       app_rd;
	pio_wmem_pkg::app_wr_t  [NT-1:0]       app_wr;
	pio_wmem_pkg::app_rsp_t [NT-1:0]       app_rsp;

	int cycle = 0;
	bit pio_done;
	bit pio_busy;  // a PIO access is waiting for its ack to rise and fall
	logic [`WMEM_WIDTH-1:0] model [NT][64];
	logic [31:0]            lo_held [NT];  // low dword waiting in each table
	logic [7:0]             hi_cap [NT];   // upper bits captured by the last low read
	int                     exp_cyc [NT][4];  // app read due cycle, slot is cycle mod 4
	logic [`WMEM_WIDTH-1:0] exp_dat [NT][4];

	pio_wmem_bank pio_wmem_bank_inst (
		.clk(clk),
		.arst_n(arst_n),
		.clk_div(clk_div),
		.pio_req(pio_req),
		.app_rd(app_rd),
		.app_wr(app_wr),
		.pio_rsp(pio_rsp),
		.app_rsp(app_rsp)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(posedge clk) begin
		#1;
		clk_div = (cycle % 3 == 0);  // one strobe every third cycle
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_pio(input string name, input pio_wmem_pkg::pio_rsp_t got,
		input pio_wmem_pkg::pio_rsp_t exp, input bit with_data);
		if (got.ack !== exp.ack || (with_data && got.rdata !== exp.rdata)) begin
			report_fail($sformatf("ERROR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_app(input string name, input pio_wmem_pkg::app_rsp_t got,
		input pio_wmem_pkg::app_rsp_t exp, input bit with_data);
		if (got.ack !== exp.ack || (with_data && got.rdata !== exp.rdata)) begin
			report_fail($sformatf("ERROR %s got %h expected %h", name, got, exp));
		end
	endtask

	// every app read must see its ack and data exactly 3 cycles after the strobe
	always @(negedge clk) begin
		pio_wmem_pkg::app_rsp_t exp;
		if (arst_n) begin
			for (int t = 0; t < NT; t++) begin
				exp.ack = (exp_cyc[t][cycle % 4] == cycle);
				exp.rdata = exp_dat[t][cycle % 4];
				check_app($sformatf("app_rsp[%0d]", t), app_rsp[t], exp, exp.ack);
			end
		end
	end

	// one ack per access, so an ack outside an access is a stray or a second one
	always @(negedge clk) begin
		if (arst_n && !pio_busy && pio_rsp.ack !== 1'b0) begin
			report_fail("PIO ack seen with no access outstanding");
		end
	end

	function automatic logic [39:0] rand40();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[39:0];
	endfunction

	function automatic logic [15:0] pio_addr(input logic [4:0] base, input int t,
		input int e, input bit hi);
		logic [1:0] ts;
		logic [5:0] es;
		ts = 2'(t);
		es = 6'(e);
		return {base, ts, es, hi, 2'b00};
	endfunction

	// called right after the drive delay, the read sees the model before this write
	task automatic issue_app(input int t, input bit rd, input int re, input bit wr,
		input int we, input logic [39:0] d);
		if (rd) begin
			app_rd[t] = {1'b1, 6'(re)};
			exp_cyc[t][(cycle + 3) % 4] = cycle + 3;
			exp_dat[t][(cycle + 3) % 4] = model[t][re];
		end
		if (wr) begin
			app_wr[t] = {1'b1, 6'(we), d};
			model[t][we] = d;
		end
	endtask

	// one app cycle followed by an idle cycle
	task automatic app_op(input int t, input bit rd, input int re, input bit wr,
		input int we, input logic [39:0] d);
		@(posedge clk);
		#1;
		issue_app(t, rd, re, wr, we, d);
		@(posedge clk);
		#1;
		app_rd = '0;
		app_wr = '0;
	endtask

	task automatic pio_access(input logic [15:0] addr, input logic [31:0] wdata,
		input bit is_rd, output pio_wmem_pkg::pio_rsp_t rsp);
		@(posedge clk);
		#1;
		pio_busy = 1'b1;
		pio_req.addr = addr;
		pio_req.wdata = wdata;
		pio_req.rd = is_rd;
		pio_req.wr = !is_rd;
		@(posedge clk);
		#1;
		pio_req = '0;
		while (pio_rsp.ack !== 1'b1) @(negedge clk);
		rsp = pio_rsp;
		while (pio_rsp.ack !== 1'b0) @(negedge clk);
		pio_busy = 1'b0;
	endtask

	task automatic pio_write_lo(input int t, input int e, input logic [31:0] d);
		pio_wmem_pkg::pio_rsp_t rsp;
		pio_access(pio_addr(`WMEM_BASE, t, e, 1'b0), d, 1'b0, rsp);
		lo_held[t] = d;
	endtask

	task automatic pio_write_hi(input int t, input int e, input logic [7:0] d);
		pio_wmem_pkg::pio_rsp_t rsp;
		pio_access(pio_addr(`WMEM_BASE, t, e, 1'b1), {24'h0, d}, 1'b0, rsp);
		model[t][e] = {d, lo_held[t]};  // the entry counts as written once acked
	endtask

	task automatic pio_read_lo(input int t, input int e);
		pio_wmem_pkg::pio_rsp_t rsp;
		pio_wmem_pkg::pio_rsp_t exp;
		pio_access(pio_addr(`WMEM_BASE, t, e, 1'b0), 32'h0, 1'b1, rsp);
		exp = {1'b1, model[t][e][31:0]};
		check_pio("pio_rsp", rsp, exp, 1'b1);
		hi_cap[t] = model[t][e][39:32];
	endtask

	task automatic pio_read_hi(input int t, input int e);
		pio_wmem_pkg::pio_rsp_t rsp;
		pio_wmem_pkg::pio_rsp_t exp;
		pio_access(pio_addr(`WMEM_BASE, t, e, 1'b1), 32'h0, 1'b1, rsp);
		exp = {1'b1, 24'h0, hi_cap[t]};
		check_pio("pio_rsp", rsp, exp, 1'b1);
	endtask

	task automatic pio_miss(input logic [4:0] base, input int t, input int e, input bit is_rd);
		pio_wmem_pkg::pio_rsp_t rsp;
		pio_wmem_pkg::pio_rsp_t exp;
		pio_access(pio_addr(base, t, e, 1'b0), $urandom(), is_rd, rsp);
		exp = {1'b1, 32'hffff_ffff};
		check_pio("pio_rsp", rsp, exp, is_rd);
	endtask

	// app traffic lands near the commit or the low read at several offsets
	task automatic collide(input int t, input int off);
		logic [39:0] d;
		d = rand40();
		pio_write_lo(t, 16 + off, d[31:0]);
		fork
			pio_write_hi(t, 16 + off, d[39:32]);
			begin
				repeat (off) @(posedge clk);
				app_op(t, 1'b1, 40 + off, 1'b1, 48 + off, rand40());
			end
		join
		fork
			pio_read_lo(t, 16 + off);
			begin
				repeat (off) @(posedge clk);
				app_op(t, 1'b1, 16 + off, 1'b1, 56 + off, rand40());
			end
		join
		pio_read_hi(t, 16 + off);
		app_op(t, 1'b1, 48 + off, 1'b0, 0, 40'h0);  // app writes made during the collisions
		app_op(t, 1'b1, 56 + off, 1'b0, 0, 40'h0);
	endtask

	task automatic random_pio(input int n);
		int t;
		int e;
		for (int i = 0; i < n; i++) begin
			t = $urandom_range(NT - 1, 0);
			e = $urandom_range(31, 0);
			case ($urandom_range(9, 0))
				0, 1: pio_write_lo(t, e, $urandom());
				2, 3: pio_write_hi(t, e, 8'($urandom()));
				4, 5: pio_read_lo(t, e);
				6, 7: pio_read_hi(t, e);
				8: pio_miss(5'($urandom_range(31, 2)), t, e, 1'b1);
				default: pio_miss(5'h00, t, e, 1'b0);
			endcase
		end
		pio_done = 1'b1;
	endtask

	// app side keeps to entries 32 and up, so it never races the PIO entries
	task automatic random_app();
		while (!pio_done) begin
			@(posedge clk);
			#1;
			for (int t = 0; t < NT; t++) begin
				issue_app(t, 1'($urandom()), $urandom_range(63, 32), 1'($urandom()),
					$urandom_range(63, 32), rand40());
			end
			@(posedge clk);
			#1;
			app_rd = '0;
			app_wr = '0;
		end
	endtask

	initial begin
		logic [39:0] d;
		void'($urandom(44));
		arst_n = 1'b0;
		clk_div = 1'b0;
		pio_req = '0;
		app_rd = '0;
		app_wr = '0;
		pio_done = 1'b0;
		pio_busy = 1'b0;
		for (int t = 0; t < NT; t++) begin
			for (int s = 0; s < 4; s++) begin
				exp_cyc[t][s] = -1;
			end
		end
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// fill every entry of every table through the app ports
		for (int e = 0; e < 64; e++) begin
			@(posedge clk);
			#1;
			for (int t = 0; t < NT; t++) begin
				issue_app(t, 1'b0, 0, 1'b1, e, {8'(t * 37 + e), 32'(t * 32'h0101_0000) ^ ~32'(e)});
			end
			@(posedge clk);
			#1;
			app_wr = '0;
		end

		for (int t = 0; t < NT; t++) begin
			d = rand40();
			pio_write_lo(t, t + 1, d[31:0]);
			pio_write_hi(t, t + 1, d[39:32]);
			pio_read_lo(t, t + 1);
			pio_read_hi(t, t + 1);
			app_op(t, 1'b1, t + 1, 1'b0, 0, 40'h0);  // PIO-written entry seen by the app
			app_op(t, 1'b0, 0, 1'b1, t + 8, rand40());
			app_op(t, 1'b1, t + 8, 1'b0, 0, 40'h0);
			pio_read_lo(t, t + 8);  // app-written entry seen by PIO
			pio_read_hi(t, t + 8);
			for (int off = 0; off < 5; off++) begin
				collide(t, off);
			end
			pio_miss(5'h02, t, t + 1, 1'b1);
			pio_miss(5'h00, t, t + 1, 1'b0);
			pio_read_lo(t, t + 1);
			pio_read_hi(t, t + 1);
		end

		fork
			random_pio(N_RANDOM);
			random_app();
		join
		repeat (8) @(posedge clk);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/pio_wmem_bank.sv */
// Top level of the wide lookup table bank. The host reaches all tables over one PIO
// bus and each table has its own full-width app read and write port.
// pio_rsp.ack is a level that rises at a clk_div strobe after the access and drops
// at the next clk_div strobe, the host waits for it before the next access.
`timescale 1ns/1ps
`default_nettype none

`include "pio_wmem_macros.svh"

module pio_wmem_bank (
	input  wire                                         clk,
	input  wire                                         arst_n,
	input  wire                                         clk_div,
	input  wire pio_wmem_pkg::pio_req_t                 pio_req,
	input  wire pio_wmem_pkg::app_rd_t  [`WMEM_NUM-1:0] app_rd,
	input  wire pio_wmem_pkg::app_wr_t  [`WMEM_NUM-1:0] app_wr,
	output wire pio_wmem_pkg::pio_rsp_t                 pio_rsp,
	output wire pio_wmem_pkg::app_rsp_t [`WMEM_NUM-1:0] app_rsp
);

	wire [`WMEM_NUM-1:0]                         tbl_ms;
	wire pio_wmem_pkg::pio_rsp_t                 miss_rsp;
	wire pio_wmem_pkg::pio_rsp_t [`WMEM_NUM-1:0] tbl_rsp;

	pio_addr_decode pio_addr_decode_inst (
		.clk(clk),
		.arst_n(arst_n),
		.clk_div(clk_div),
		.pio_req(pio_req),
		.tbl_ms(tbl_ms),
		.miss_rsp(miss_rsp)
	);

	// every table sees the whole PIO request, its select bit picks the owner
	for (genvar i = 0; i < `WMEM_NUM; i++) begin : g_tbl
		pio_rw_wmem pio_rw_wmem_inst (
			.clk(clk),
			.arst_n(arst_n),
			.clk_div(clk_div),
			.pio_req(pio_req),
			.ms(tbl_ms[i]),
			.app_rd(app_rd[i]),
			.app_wr(app_wr[i]),
			.pio_rsp(tbl_rsp[i]),
			.app_rsp(app_rsp[i])
		);
	end

	pio_rdata_merge pio_rdata_merge_inst (
		.clk(clk),
		.arst_n(arst_n),
		.tbl_rsp(tbl_rsp),
		.miss_rsp(miss_rsp),
		.pio_rsp(pio_rsp)
	);

endmodule

`default_nettype wire

/* rtl/pio_rdata_merge.sv */
// Joins the PIO responses of all tables and of the address decoder into the one
// bank response. Only one source acknowledges at a time, so the read data is the
// OR of the data of the sources whose ack is high. Output is registered.
`timescale 1ns/1ps
`default_nettype none

`include "pio_wmem_macros.svh"

module pio_rdata_merge (
	input  wire                                         clk,
	input  wire                                         arst_n,
	input  wire pio_wmem_pkg::pio_rsp_t [`WMEM_NUM-1:0] tbl_rsp,
	input  wire pio_wmem_pkg::pio_rsp_t                 miss_rsp,
	output pio_wmem_pkg::pio_rsp_t                      pio_rsp
);

	logic [`WMEM_NUM:0]    acks;  // tables, then the decoder in the top bit
	logic [`PIO_NBITS-1:0] sel_rdata;
	logic                  ack_q;
	logic [`PIO_NBITS-1:0] rdata_q;

	always_comb begin
		sel_rdata = miss_rsp.rdata & {`PIO_NBITS{miss_rsp.ack}};
		acks[`WMEM_NUM] = miss_rsp.ack;
		for (int i = 0; i < `WMEM_NUM; i++) begin
			acks[i] = tbl_rsp[i].ack;
			sel_rdata = sel_rdata | (tbl_rsp[i].rdata & {`PIO_NBITS{tbl_rsp[i].ack}});
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= |acks;
		end
	end

	always_ff @(posedge clk) begin
		rdata_q <= sel_rdata;
	end

	assign pio_rsp.ack = ack_q;
	assign pio_rsp.rdata = rdata_q;

	// the PIO master waits for ack, so acks of two sources never overlap
	a_single_source: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(acks))
		else $error("two PIO sources acknowledge in one cycle");

endmodule

`default_nettype wire

/* rtl/pio_addr_decode.sv */
// PIO address decoder for the table bank. Drives a one-hot table select for
// accesses inside the bank window and acknowledges everything outside the window
// itself, returning all-ones read data under the same clk_div ack rule as a table.
`timescale 1ns/1ps
`default_nettype none

`include "pio_wmem_macros.svh"

module pio_addr_decode (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         clk_div,
	input  wire pio_wmem_pkg::pio_req_t pio_req,
	output logic [`WMEM_NUM-1:0]        tbl_ms,
	output pio_wmem_pkg::pio_rsp_t      miss_rsp
);

	logic                       strobe;
	logic                       in_win;
	logic [`WMEM_SEL_NBITS-1:0] sel;
	logic                       miss_pend;
	logic                       miss_ack_q;

	assign strobe = pio_req.rd | pio_req.wr;
	assign in_win = pio_req.addr[`PIO_ADDR_NBITS-1:`PIO_BASE_LSB] == `WMEM_BASE;
	assign sel = pio_req.addr[`PIO_SEL_LSB +: `WMEM_SEL_NBITS];

	always_comb begin
		tbl_ms = '0;
		if (strobe && in_win) begin
			tbl_ms[sel] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			miss_pend <= 1'b0;
			miss_ack_q <= 1'b0;
		end else begin
			if (strobe && !in_win) begin
				miss_pend <= 1'b1;
			end else if (clk_div) begin
				miss_pend <= 1'b0;
			end
			if (clk_div) begin
				miss_ack_q <= miss_pend;  // held until the next strobe
			end
		end
	end

	assign miss_rsp.ack = miss_ack_q;
	assign miss_rsp.rdata = '1;

	// the master waits for ack, so no access arrives while a miss is still open
	a_miss_single: assert property (@(posedge clk) disable iff (!arst_n)
		strobe |-> !miss_pend && !miss_ack_q)
		else $error("PIO access while a miss is outstanding");

endmodule

`default_nettype wire

/* rtl/pio_rw_wmem.sv */
// One wide table reachable from the PIO bus and from a full-width app port.
// PIO splits each 40-bit entry into a low and a high dword: the low write is held
// until the high write commits the entry, and the low read captures the upper bits
// for the following high read. App accesses win the RAM, a colliding PIO access
// waits one cycle in a save flag. App read latency is a fixed 3 cycles.
`timescale 1ns/1ps
`default_nettype none

`include "pio_wmem_macros.svh"

module pio_rw_wmem (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         clk_div,
	input  wire pio_wmem_pkg::pio_req_t pio_req,
	input  wire                         ms,
	input  wire pio_wmem_pkg::app_rd_t  app_rd,
	input  wire pio_wmem_pkg::app_wr_t  app_wr,
	output pio_wmem_pkg::pio_rsp_t      pio_rsp,
	output pio_wmem_pkg::app_rsp_t      app_rsp
);

	localparam int HI_NBITS = `WMEM_WIDTH - `PIO_NBITS;

	pio_wmem_pkg::app_rd_t app_rd_q;
	pio_wmem_pkg::app_wr_t app_wr_q;
	logic                  app_rd_d2;
	logic                  app_ack_q;
	logic [`WMEM_WIDTH-1:0] app_rdata_q;

	logic [`WMEM_DEPTH_NBITS-1:0] pio_entry_q;
	logic [`PIO_NBITS-1:0]        pio_wdata_q;
	logic [`PIO_NBITS-1:0]        wdata_lo;  // low dword waiting for its high half
	logic [HI_NBITS-1:0]          rdata_hi;  // upper bits captured by the low read
	logic                         wr_lo_d1;
	logic                         wr_hi_d1;
	logic                         rd_lo_d1;
	logic                         rd_hi_d1;
	logic                         wr_save;
	logic                         rd_save;
	logic                         rd_go_d1;
	logic                         pend;
	logic                         pio_ack_q;
	logic [`PIO_NBITS-1:0]        pio_rdata_q;

	logic                         pio_hit;
	logic                         pio_dw_hi;
	logic                         commit_req;
	logic                         commit_go;
	logic                         rd_req;
	logic                         rd_go;
	logic                         ram_wr;
	logic [`WMEM_DEPTH_NBITS-1:0] ram_raddr;
	logic [`WMEM_DEPTH_NBITS-1:0] ram_waddr;
	logic [`WMEM_WIDTH-1:0]       ram_din;
	logic [`WMEM_WIDTH-1:0]       ram_dout;

	assign pio_hit = ms & (pio_req.rd | pio_req.wr);
	assign pio_dw_hi = pio_req.addr[`PIO_DW_BIT];

	// a deferred access stays requested until the app port leaves the RAM free
	assign commit_req = wr_hi_d1 | wr_save;
	assign commit_go = commit_req & ~app_wr_q.wr;
	assign rd_req = rd_lo_d1 | rd_save;
	assign rd_go = rd_req & ~app_rd_q.rd;

	assign ram_wr = app_wr_q.wr | commit_go;
	assign ram_waddr = app_wr_q.wr ? app_wr_q.addr : pio_entry_q;
	assign ram_din = app_wr_q.wr ? app_wr_q.wdata : {pio_wdata_q[HI_NBITS-1:0], wdata_lo};
	assign ram_raddr = app_rd_q.rd ? app_rd_q.addr : pio_entry_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			app_rd_q <= '0;
			app_wr_q <= '0;
			app_rd_d2 <= 1'b0;
			app_ack_q <= 1'b0;
		end else begin
			app_rd_q <= app_rd;
			app_wr_q <= app_wr;
			app_rd_d2 <= app_rd_q.rd;  // RAM output is valid in this cycle
			app_ack_q <= app_rd_d2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_lo_d1 <= 1'b0;
			wr_hi_d1 <= 1'b0;
			rd_lo_d1 <= 1'b0;
			rd_hi_d1 <= 1'b0;
			wr_save <= 1'b0;
			rd_save <= 1'b0;
			rd_go_d1 <= 1'b0;
			pend <= 1'b0;
			pio_ack_q <= 1'b0;
		end else begin
			wr_lo_d1 <= pio_hit & pio_req.wr & ~pio_dw_hi;
			wr_hi_d1 <= pio_hit & pio_req.wr & pio_dw_hi;
			rd_lo_d1 <= pio_hit & pio_req.rd & ~pio_dw_hi;
			rd_hi_d1 <= pio_hit & pio_req.rd & pio_dw_hi;
			wr_save <= commit_req & app_wr_q.wr;
			rd_save <= rd_req & app_rd_q.rd;
			rd_go_d1 <= rd_go;

			// the access wins over a clk_div in the same cycle
			if (wr_lo_d1 | commit_go | rd_go_d1 | rd_hi_d1) begin
				pend <= 1'b1;
			end else if (clk_div) begin
				pend <= 1'b0;
			end
			if (clk_div) begin
				pio_ack_q <= pend;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pio_hit) begin
			pio_entry_q <= pio_req.addr[`PIO_ENTRY_LSB +: `WMEM_DEPTH_NBITS];
			pio_wdata_q <= pio_req.wdata;
		end
		if (wr_lo_d1) begin
			wdata_lo <= pio_wdata_q;
		end
		if (rd_go_d1) begin
			pio_rdata_q <= ram_dout[`PIO_NBITS-1:0];
			rdata_hi <= ram_dout[`WMEM_WIDTH-1:`PIO_NBITS];
		end else if (rd_hi_d1) begin
			pio_rdata_q <= {{(`PIO_NBITS-HI_NBITS){1'b0}}, rdata_hi};
		end
		if (app_rd_d2) begin
			app_rdata_q <= ram_dout;
		end
	end

	assign pio_rsp.ack = pio_ack_q;
	assign pio_rsp.rdata = pio_rdata_q;
	assign app_rsp.ack = app_ack_q;
	assign app_rsp.rdata = app_rdata_q;

	ram_1r1w #(
		.WIDTH(`WMEM_WIDTH),
		.DEPTH_NBITS(`WMEM_DEPTH_NBITS)
	) ram_1r1w_inst (
		.clk(clk),
		.wr(ram_wr),
		.raddr(ram_raddr),
		.waddr(ram_waddr),
		.din(ram_din),
		.dout(ram_dout)
	);

	// app strobes are single-cycle pulses, so a deferred access gets the RAM next cycle
	a_wr_save_short: assert property (@(posedge clk) disable iff (!arst_n)
		wr_save |=> !wr_save) else $error("PIO commit deferred more than one cycle");
	a_rd_save_short: assert property (@(posedge clk) disable iff (!arst_n)
		rd_save |=> !rd_save) else $error("PIO read deferred more than one cycle");
	a_ms_single_op: assert property (@(posedge clk) disable iff (!arst_n)
		ms |-> !(pio_req.rd && pio_req.wr)) else $error("PIO select with rd and wr");

endmodule

`default_nettype wire

/* rtl/ram_1r1w.sv */
// Simple dual-port RAM, one write port and one registered read port.
// A read of the address written in the same cycle returns the old entry.
`timescale 1ns/1ps
`default_nettype none

module ram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH_NBITS = 8
) (
	input  wire                   clk,
	input  wire                   wr,
	input  wire [DEPTH_NBITS-1:0] raddr,
	input  wire [DEPTH_NBITS-1:0] waddr,
	input  wire [WIDTH-1:0]       din,
	output logic [WIDTH-1:0]      dout
);

	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// nonblocking read sees the entry as it was before this cycle's write
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

	a_waddr_known: assert property (@(posedge clk) wr |-> !$isunknown(waddr))
		else $error("ram write with unknown address");

endmodule

`default_nettype wire

/* rtl/pio_wmem_pkg.sv */
// Packed struct types for the PIO register bus and the application table ports.
// Shared by the RTL and the testbench, always referenced by scoped name.
`default_nettype none

`include "pio_wmem_macros.svh"

package pio_wmem_pkg;

	// one PIO access, exactly one of rd and wr is set for a valid strobe
	typedef struct packed {
		logic [`PIO_ADDR_NBITS-1:0] addr;
		logic [`PIO_NBITS-1:0]      wdata;
		logic                       rd;
		logic                       wr;
	} pio_req_t;

	// ack is a level, rdata is valid while it is high
	typedef struct packed {
		logic                  ack;
		logic [`PIO_NBITS-1:0] rdata;
	} pio_rsp_t;

	typedef struct packed {
		logic                         rd;
		logic [`WMEM_DEPTH_NBITS-1:0] addr;
	} app_rd_t;

	typedef struct packed {
		logic                         wr;
		logic [`WMEM_DEPTH_NBITS-1:0] addr;
		logic [`WMEM_WIDTH-1:0]       wdata;
	} app_wr_t;

	// read data arrives together with ack, a fixed 3 cycles after the strobe
	typedef struct packed {
		logic                   ack;
		logic [`WMEM_WIDTH-1:0] rdata;
	} app_rsp_t;

endpackage

`default_nettype wire

/* rtl/pio_wmem_macros.svh */
// Shared constants for the wide lookup table bank: PIO bus widths, table geometry
// and the PIO address map. Include this wherever one of the macros is needed.
// Address map: bit 2 selects the dword, bits 8:3 the entry, bits 10:9 the table,
// and bits 15:11 must match the bank window.
`ifndef PIO_WMEM_MACROS_SVH
`define PIO_WMEM_MACROS_SVH

`define PIO_NBITS         32
`define PIO_ADDR_NBITS    16

`define WMEM_WIDTH        40
`define WMEM_DEPTH_NBITS  6
`define WMEM_NUM          4
`define WMEM_SEL_NBITS    2

// bit positions inside the PIO byte address
`define PIO_DW_BIT        2
`define PIO_ENTRY_LSB     3
`define PIO_SEL_LSB       (`PIO_ENTRY_LSB + `WMEM_DEPTH_NBITS)
`define PIO_BASE_LSB      (`PIO_SEL_LSB + `WMEM_SEL_NBITS)

// value of the address bits above the table index for the bank window
`define WMEM_BASE         5'h01

`endif
